// ==== l1_cache.f ====
+incdir+.
l1_cache_pkg.sv
l1_cache_tag_array.sv
l1_cache_data_array.sv
l1_cache_controller.sv
l1_cache.sv
l1_cache_checker.sv
dram_model.sv
tb_l1_cache.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_l1_cache
FILELIST  ?= l1_cache.f
VFLAGS    ?= --binary --timing --assert -j 0
RUNFLAGS  ?= +verilator+error+limit+100

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard *.svh)
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUNFLAGS)

clean:
	rm -rf obj_dir

// ==== tb_l1_cache.sv ====
`timescale 1ns/1ps

`include "l1_cache_defines.svh"

module tb_l1_cache;

	localparam int CYCLE_LIMIT = 6000; // 300 ops at ~14 cycles plus directed tests
	localparam int ACK_LIMIT   = 64;

	logic                    clk;
	logic                    rst;
	logic                    cpu_cs;
	logic                    cpu_we;
	logic [`L1_ADDR_W-1:0]   cpu_addr;
	logic [`L1_DATA_W-1:0]   cpu_wdata;
	logic [`L1_DATA_W-1:0]   cpu_rdata;
	logic                    cpu_ack;
	logic                    mem_cs;
	logic                    mem_we;
	logic [`L1_ADDR_W-1:0]   mem_addr;
	logic [`L1_DATA_W-1:0]   mem_wdata;
	logic [`L1_DATA_W-1:0]   mem_rdata;
	logic                    mem_ack;
	int unsigned             dram_reads;
	int unsigned             dram_writes;

	logic [`L1_DATA_W-1:0]   ref_mem [1 << `L1_ADDR_W];
	logic [`L1_ADDR_W-1:0]   line_addr [`L1_LINES]; // Expected occupant of each line
	logic [`L1_LINES-1:0]    line_valid;
	logic [`L1_LINES-1:0]    line_dirty;
	l1_cache_pkg::cache_op_e cur_op;
	logic [`L1_ADDR_W-1:0]   cur_addr;
	logic [`L1_ADDR_W-1:0]   wb_addr;
	logic [31:0]             rnd;
	logic [31:0]             rnd_data;
	int                      seed;
	int                      cycles = 0;

	l1_cache DUT (.*);

	dram_model u_dram
	(
		.clk(clk), .rst(rst), .mem_cs(mem_cs), .mem_we(mem_we),
		.mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
		.mem_ack(mem_ack), .read_count(dram_reads), .write_count(dram_writes)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [`L1_DATA_W-1:0] ref_read(input logic [`L1_ADDR_W-1:0] addr);
		return ref_mem[addr];
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1, "Stopping at the first error");
	endtask

	task automatic check_rdata(input logic [`L1_DATA_W-1:0] got, input logic [`L1_DATA_W-1:0] exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED at %0t: cpu_rdata got %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_writeback(input logic [`L1_ADDR_W-1:0] got_addr,
		input logic [`L1_DATA_W-1:0] got_data, input logic [`L1_ADDR_W-1:0] exp_addr,
		input logic [`L1_DATA_W-1:0] exp_data);
		if (got_addr !== exp_addr)
			abort_run($sformatf("CHECK FAILED at %0t: mem_addr got %h, expected %h",
				$time, got_addr, exp_addr));
		else if (got_data !== exp_data)
			abort_run($sformatf("CHECK FAILED at %0t: mem_wdata got %h, expected %h",
				$time, got_data, exp_data));
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp)
			abort_run($sformatf("CHECK FAILED at %0t: cpu_ack latency got %0d, expected %0d",
				$time, got, exp));
	endtask

	// One CPU request, checked against the expected line state
	task automatic cpu_access(input logic we, input logic [`L1_ADDR_W-1:0] addr,
		input logic [`L1_DATA_W-1:0] data);
		logic [`L1_INDEX_W-1:0] idx;
		logic                   line_hit;
		logic                   expect_wb;
		int unsigned            reads_before;
		int unsigned            writes_before;
		int                     edges;
		idx       = addr[`L1_INDEX_W-1:0];
		line_hit  = line_valid[idx] && (line_addr[idx] == addr);
		expect_wb = !line_hit && line_valid[idx] && line_dirty[idx];
		@(negedge clk);
		wb_addr       = line_addr[idx];
		cur_addr      = addr;
		cur_op        = we ? l1_cache_pkg::OP_WRITE : l1_cache_pkg::OP_READ;
		reads_before  = dram_reads;
		writes_before = dram_writes;
		cpu_cs        = 1'b1;
		cpu_we        = we;
		cpu_addr      = addr;
		cpu_wdata     = data;
		edges         = 0;
		do
		begin
			@(negedge clk);
			edges++;
		end
		while (!cpu_ack && edges < ACK_LIMIT);
		if (!cpu_ack)
			abort_run($sformatf("Request to address %h got no cpu_ack within %0d cycles",
				addr, ACK_LIMIT));
		cpu_cs = 1'b0;
		cpu_we = 1'b0;
		if (line_hit)
			check_latency(edges, we ? 3 : 2);
		if (dram_writes - writes_before != (expect_wb ? 1 : 0))
			abort_run("Number of DRAM writes does not match the expected victim writeback");
		if (dram_reads - reads_before != ((!line_hit && !we) ? 1 : 0))
			abort_run("Number of DRAM reads does not match the expected refill");
		if (we)
			ref_mem[addr] = data;
		line_addr[idx]  = addr;
		line_valid[idx] = 1'b1;
		line_dirty[idx] = we || (line_hit && line_dirty[idx]);
	endtask

	// Values sampled before the DUT updates on this edge
	always @(posedge clk)
	begin
		if (rst && cpu_ack && cur_op == l1_cache_pkg::OP_READ)
			check_rdata(cpu_rdata, ref_read(cur_addr));
		if (rst && mem_ack && mem_we)
			check_writeback(mem_addr, mem_wdata, wb_addr, ref_read(wb_addr));
	end

	always @(negedge clk)
	begin
		cycles++;
		if (cycles >= CYCLE_LIMIT)
			abort_run("Timeout, the test did not finish within the cycle limit");
		else if (DUT.u_ctrl.u_checker.ack_fail || DUT.u_ctrl.u_checker.hold_fail
			|| DUT.u_ctrl.u_checker.excl_fail || DUT.u_ctrl.u_checker.reset_fail)
			abort_run("A handshake assertion on the cache controller failed");
	end

	initial
	begin
		logic [`L1_ADDR_W-1:0] a;
		seed      = 32'h9607;
		rst       = 1'b0;
		cpu_cs    = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		cur_op    = l1_cache_pkg::OP_READ;
		cur_addr  = '0;
		wb_addr   = '0;
		for (int i = 0; i < (1 << `L1_ADDR_W); i++)
		begin
			a          = i[`L1_ADDR_W-1:0];
			ref_mem[i] = {~a, a}; // Same fill rule as DRAM
		end
		for (int i = 0; i < `L1_LINES; i++)
			line_addr[i] = '0;
		line_valid = '0;
		line_dirty = '0;
		repeat (3) @(negedge clk);
		rst = 1'b1;

		repeat (4)
		begin
			@(negedge clk);
			if (cpu_ack || mem_cs)
				abort_run("cpu_ack or mem_cs went high with no request pending");
		end

		cpu_access(1'b0, 16'h0005, '0); // Cold miss
		cpu_access(1'b1, 16'h0005, 32'hcafe_0005);
		cpu_access(1'b0, 16'h0005, '0); // Read hit, 2 cycles
		cpu_access(1'b0, 16'h0015, '0); // Evicts dirty 0x0005
		cpu_access(1'b1, 16'h0025, 32'h1234_0025); // Write miss over clean line
		cpu_access(1'b0, 16'h0025, '0);
		cpu_access(1'b1, 16'h0109, 32'h0bad_0109); // Invalid line
		cpu_access(1'b0, 16'h0109, '0);

		repeat (300)
		begin
			rnd      = $random(seed);
			rnd_data = $random(seed);
			cpu_access(rnd[8], {{(`L1_ADDR_W - 6){1'b0}}, rnd[5:0]}, rnd_data);
		end

		repeat (4) @(negedge clk);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== dram_model.sv ====
`timescale 1ns/1ps

`include "l1_cache_defines.svh"

module dram_model
(
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  mem_cs,
	input  logic                  mem_we,
	input  logic [`L1_ADDR_W-1:0] mem_addr,
	input  logic [`L1_DATA_W-1:0] mem_wdata,
	output logic [`L1_DATA_W-1:0] mem_rdata,
	output logic                  mem_ack,
	output int unsigned           read_count,
	output int unsigned           write_count // Write log seen by the testbench
);

	logic [`L1_DATA_W-1:0] words [1 << `L1_ADDR_W];
	logic [`L1_ADDR_W-1:0] a;
	logic                  busy;
	int                    delay;
	int                    seed;

	// One process drives every output on the falling edge
	initial
	begin
		seed        = 32'h9607;
		busy        = 1'b0;
		delay       = 0;
		mem_ack     = 1'b0;
		mem_rdata   = '0;
		read_count  = 0;
		write_count = 0;
		for (int i = 0; i < (1 << `L1_ADDR_W); i++)
		begin
			a        = i[`L1_ADDR_W-1:0];
			words[i] = {~a, a}; // Inverted address high, address low
		end
		forever
		begin
			@(negedge clk);
			if (!rst || mem_ack)
			begin
				busy    = 1'b0;
				mem_ack = 1'b0;
			end
			else if (mem_cs)
			begin
				if (!busy)
				begin
					busy  = 1'b1;
					delay = $random(seed) & 3; // Ack after 1 to 4 cycles
				end
				if (delay > 0)
					delay--;
				else
				begin
					if (mem_we)
					begin
						words[mem_addr] = mem_wdata;
						write_count++;
					end
					else
					begin
						mem_rdata = words[mem_addr];
						read_count++;
					end
					mem_ack = 1'b1;
				end
			end
		end
	end

endmodule

// ==== l1_cache_checker.sv ====
`timescale 1ns/1ps

`include "l1_cache_defines.svh"

module l1_cache_checker
(
	input logic                       clk,
	input logic                       rst,
	input l1_cache_pkg::cache_state_e state,
	input logic                       cpu_ack,
	input logic                       mem_cs,
	input logic                       mem_we,
	input logic                       mem_ack,
	input logic                       mem_addr_sel,
	input logic [`L1_ADDR_W-1:0]      req_addr
);

	// Sticky per rule, watched by the testbench
	logic ack_fail   = 1'b0;
	logic hold_fail  = 1'b0;
	logic excl_fail  = 1'b0;
	logic reset_fail = 1'b0;

	ack_single: assert property (@(posedge clk) disable iff (!rst) cpu_ack |=> !cpu_ack)
	else
	begin
		ack_fail = 1'b1;
		$error("cpu_ack stayed high for more than one cycle");
	end

	// mem_addr is built from req_addr and the select
	mem_hold: assert property (@(posedge clk) disable iff (!rst)
		mem_cs && !mem_ack |=> mem_cs && $stable(mem_we) && $stable(mem_addr_sel)
			&& $stable(req_addr))
	else
	begin
		hold_fail = 1'b1;
		$error("DRAM request changed before mem_ack");
	end

	ack_mem_excl: assert property (@(posedge clk) disable iff (!rst) !(cpu_ack && mem_cs))
	else
	begin
		excl_fail = 1'b1;
		$error("cpu_ack and mem_cs high together");
	end

	reset_quiet: assert property (@(posedge clk)
		!rst |=> state == l1_cache_pkg::IDLE && !cpu_ack && !mem_cs)
	else
	begin
		reset_fail = 1'b1;
		$error("Controller active during reset");
	end

endmodule

bind l1_cache_controller l1_cache_checker u_checker (.*);

// ==== l1_cache.sv ====
`timescale 1ns/1ps

`include "l1_cache_defines.svh"

module l1_cache
(
	input  logic                  clk,
	input  logic                  rst,

	input  logic                  cpu_cs,
	input  logic                  cpu_we,
	input  logic [`L1_ADDR_W-1:0] cpu_addr,
	input  logic [`L1_DATA_W-1:0] cpu_wdata,
	output logic [`L1_DATA_W-1:0] cpu_rdata,
	output logic                  cpu_ack,

	output logic                  mem_cs,
	output logic                  mem_we,
	output logic [`L1_ADDR_W-1:0] mem_addr,
	output logic [`L1_DATA_W-1:0] mem_wdata,
	input  logic [`L1_DATA_W-1:0] mem_rdata,
	input  logic                  mem_ack
);

	logic [`L1_ADDR_W-1:0]   req_addr;
	logic [`L1_DATA_W-1:0]   req_wdata;
	logic [`L1_INDEX_W-1:0]  index;
	logic [`L1_TAG_W-1:0]    tag;
	logic [`L1_TAG_W-1:0]    victim_tag;
	logic [`L1_DATA_W-1:0]   rdata;
	logic                    hit;
	logic                    victim_dirty;
	logic                    tag_we;
	logic                    dirty_we;
	logic                    dirty_val;
	logic                    data_we;
	logic                    mem_addr_sel;
	l1_cache_pkg::data_src_e data_src;

	assign index = req_addr[`L1_INDEX_W-1:0];
	assign tag   = req_addr[`L1_ADDR_W-1:`L1_INDEX_W];

	// Victim address during writeback, request address otherwise
	assign mem_addr  = mem_addr_sel ? {victim_tag, index} : req_addr;
	assign mem_wdata = rdata;
	assign cpu_rdata = rdata;

	l1_cache_controller u_ctrl
	(
		.clk(clk), .rst(rst),
		.cpu_cs(cpu_cs), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_wdata(cpu_wdata),
		.cpu_ack(cpu_ack), .hit(hit), .victim_dirty(victim_dirty),
		.req_addr(req_addr), .req_wdata(req_wdata),
		.tag_we(tag_we), .dirty_we(dirty_we), .dirty_val(dirty_val),
		.data_we(data_we), .data_src(data_src), .mem_addr_sel(mem_addr_sel),
		.mem_cs(mem_cs), .mem_we(mem_we), .mem_ack(mem_ack)
	);

	l1_cache_tag_array u_tags
	(
		.clk(clk), .rst(rst), .index(index), .tag(tag),
		.tag_we(tag_we), .dirty_we(dirty_we), .dirty_val(dirty_val),
		.hit(hit), .victim_dirty(victim_dirty), .victim_tag(victim_tag)
	);

	l1_cache_data_array u_data
	(
		.clk(clk), .index(index), .data_we(data_we), .data_src(data_src),
		.cpu_wdata(req_wdata), .mem_rdata(mem_rdata), .rdata(rdata)
	);

endmodule

// ==== l1_cache_controller.sv ====
`timescale 1ns/1ps

`include "l1_cache_defines.svh"

module l1_cache_controller
(
	input  logic                    clk,
	input  logic                    rst,

	input  logic                    cpu_cs,
	input  logic                    cpu_we,
	input  logic [`L1_ADDR_W-1:0]   cpu_addr,
	input  logic [`L1_DATA_W-1:0]   cpu_wdata,
	output logic                    cpu_ack,

	input  logic                    hit,
	input  logic                    victim_dirty,
	output logic [`L1_ADDR_W-1:0]   req_addr,
	output logic [`L1_DATA_W-1:0]   req_wdata,
	output logic                    tag_we,
	output logic                    dirty_we,
	output logic                    dirty_val,
	output logic                    data_we,
	output l1_cache_pkg::data_src_e data_src,

	output logic                    mem_addr_sel,
	output logic                    mem_cs,
	output logic                    mem_we,
	input  logic                    mem_ack
);

	l1_cache_pkg::cache_state_e state;
	l1_cache_pkg::cache_state_e next_state;
	l1_cache_pkg::cache_op_e    req_op;
	logic                       req_miss;
	logic                       refill_done;

	always_comb
	begin
		next_state = state;
		case (state)
			l1_cache_pkg::IDLE:
			begin
				if (cpu_cs)
				begin
					next_state = l1_cache_pkg::LOOKUP;
				end
			end
			l1_cache_pkg::LOOKUP:
			begin
				if (hit)
				begin
					if (req_op == l1_cache_pkg::OP_READ)
					begin
						next_state = l1_cache_pkg::RESPOND;
					end
					else
					begin
						next_state = l1_cache_pkg::UPDATE;
					end
				end
				else if (victim_dirty)
				begin
					next_state = l1_cache_pkg::WRITEBACK;
				end
				else if (req_op == l1_cache_pkg::OP_READ)
				begin
					next_state = l1_cache_pkg::REFILL;
				end
				else
				begin
					next_state = l1_cache_pkg::UPDATE; // Word covers the whole line
				end
			end
			l1_cache_pkg::WRITEBACK:
			begin
				if (mem_ack)
				begin
					if (req_op == l1_cache_pkg::OP_READ)
					begin
						next_state = l1_cache_pkg::REFILL;
					end
					else
					begin
						next_state = l1_cache_pkg::UPDATE;
					end
				end
			end
			l1_cache_pkg::REFILL:
			begin
				if (mem_ack)
				begin
					next_state = l1_cache_pkg::RESPOND;
				end
			end
			l1_cache_pkg::UPDATE:  next_state = l1_cache_pkg::RESPOND;
			l1_cache_pkg::RESPOND: next_state = l1_cache_pkg::IDLE;
			default:               next_state = l1_cache_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state    <= l1_cache_pkg::IDLE;
			cpu_ack  <= 1'b0;
			req_miss <= 1'b0;
		end
		else
		begin
			state    <= next_state;
			cpu_ack  <= (next_state == l1_cache_pkg::RESPOND); // High only in RESPOND
			if (state == l1_cache_pkg::LOOKUP)
			begin
				req_miss <= !hit;
			end
		end
	end

	// Request payload captured on acceptance
	always_ff @(posedge clk)
	begin
		if (state == l1_cache_pkg::IDLE && cpu_cs)
		begin
			req_addr  <= cpu_addr;
			req_wdata <= cpu_wdata;
			req_op    <= cpu_we ? l1_cache_pkg::OP_WRITE : l1_cache_pkg::OP_READ;
		end
	end

	assign refill_done = (state == l1_cache_pkg::REFILL) && mem_ack;

	always_comb
	begin
		tag_we       = refill_done || (state == l1_cache_pkg::UPDATE && req_miss);
		dirty_we     = refill_done || (state == l1_cache_pkg::UPDATE);
		dirty_val    = (state == l1_cache_pkg::UPDATE); // Refilled lines stay clean
		data_we      = refill_done || (state == l1_cache_pkg::UPDATE);
		data_src     = refill_done ? l1_cache_pkg::SRC_MEM : l1_cache_pkg::SRC_CPU;
		mem_addr_sel = (state == l1_cache_pkg::WRITEBACK);
		mem_cs       = (state == l1_cache_pkg::WRITEBACK) || (state == l1_cache_pkg::REFILL);
		mem_we       = (state == l1_cache_pkg::WRITEBACK);
	end

endmodule

// ==== l1_cache_data_array.sv ====
`timescale 1ns/1ps

`include "l1_cache_defines.svh"

module l1_cache_data_array
(
	input  logic                     clk,
	input  logic [`L1_INDEX_W-1:0]   index,
	input  logic                     data_we,
	input  l1_cache_pkg::data_src_e  data_src,
	input  logic [`L1_DATA_W-1:0]    cpu_wdata,
	input  logic [`L1_DATA_W-1:0]    mem_rdata,
	output logic [`L1_DATA_W-1:0]    rdata
);

	logic [`L1_DATA_W-1:0] mem [`L1_LINES];
	logic [`L1_DATA_W-1:0] wdata;

	// Refill and CPU store share the single write port
	always_comb
	begin
		if (data_src == l1_cache_pkg::SRC_MEM)
		begin
			wdata = mem_rdata;
		end
		else
		begin
			wdata = cpu_wdata;
		end
	end

	always_ff @(posedge clk)
	begin
		if (data_we)
		begin
			mem[index] <= wdata;
		end
	end

	assign rdata = mem[index]; // Async read

endmodule

// ==== l1_cache_tag_array.sv ====
`timescale 1ns/1ps

`include "l1_cache_defines.svh"

module l1_cache_tag_array
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`L1_INDEX_W-1:0] index,
	input  logic [`L1_TAG_W-1:0]   tag,
	input  logic                   tag_we,
	input  logic                   dirty_we,
	input  logic                   dirty_val,
	output logic                   hit,
	output logic                   victim_dirty,
	output logic [`L1_TAG_W-1:0]   victim_tag
);

	logic [`L1_LINES-1:0] valid;
	logic [`L1_LINES-1:0] dirty;
	logic [`L1_TAG_W-1:0] tags [`L1_LINES];

	// Valid bits are the only state cleared by reset
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			valid <= '0;
		end
		else if (tag_we)
		begin
			valid[index] <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (tag_we)
		begin
			tags[index] <= tag;
		end
	end

	// A fresh tag comes in clean unless dirty is written alongside
	always_ff @(posedge clk)
	begin
		if (dirty_we)
		begin
			dirty[index] <= dirty_val;
		end
		else if (tag_we)
		begin
			dirty[index] <= 1'b0;
		end
	end

	always_comb
	begin
		victim_tag   = tags[index];
		hit          = valid[index] && (tags[index] == tag);
		victim_dirty = valid[index] && dirty[index]; // Needs writeback on a miss
	end

endmodule

// ==== l1_cache_pkg.sv ====
package l1_cache_pkg;

	// Controller states
	typedef enum logic [2:0]
	{
		IDLE      = 3'd0,
		LOOKUP    = 3'd1,
		WRITEBACK = 3'd2, // Dirty victim out to DRAM
		REFILL    = 3'd3,
		UPDATE    = 3'd4, // CPU word into the line
		RESPOND   = 3'd5
	} cache_state_e;

	// Latched request kind
	typedef enum logic
	{
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} cache_op_e;

	// Data array write source
	typedef enum logic
	{
		SRC_CPU = 1'b0,
		SRC_MEM = 1'b1
	} data_src_e;

endpackage

// ==== l1_cache_defines.svh ====
`ifndef L1_CACHE_DEFINES_SVH
`define L1_CACHE_DEFINES_SVH

// Word address into DRAM
`define L1_ADDR_W 16

// CPU and DRAM data word
`define L1_DATA_W 32

// 16 lines of one word each
`define L1_INDEX_W 4

// Upper address bits kept per line
`define L1_TAG_W (`L1_ADDR_W - `L1_INDEX_W)

// Line count derived from the index
`define L1_LINES (1 << `L1_INDEX_W)

`endif
